// File: dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

    // datapath and register file
    localparam int xlen         = 32;
    localparam int reg_num      = 32;
    localparam int reg_addr_len = 5;

    // reorder buffer
    localparam int rob_size    = 8;
    localparam int rob_tag_len = 3;

    // one reservation station per unit
    localparam int fu_num = 4;

    // value doubles as the reservation station index
    typedef enum logic [$clog2(fu_num)-1:0] {
        fu_alu  = 2'd0,
        fu_mult = 2'd1,
        fu_btu  = 2'd2,
        fu_lsu  = 2'd3
    } fu_t;

    typedef struct packed {
        logic                    valid;
        fu_t                     fu;
        logic [3:0]              func;
        logic [reg_addr_len-1:0] dest;
        logic [reg_addr_len-1:0] src1;
        logic [reg_addr_len-1:0] src2;
        logic [xlen-1:0]         imm;
        logic                    imm_valid;
        logic [xlen-1:0]         pc;
        logic                    pc_valid;
    } decoded_pack_t;

    typedef struct packed {
        logic                    busy;
        logic                    done;
        logic [reg_addr_len-1:0] dest;
        logic [xlen-1:0]         npc;
        logic [xlen-1:0]         value;
    } rob_entry_t;

endpackage

`default_nettype wire

// File: dispatch_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// rename lookups and tag assignment
interface rename_if
    import dispatch_pkg::*;
();
    logic [reg_addr_len-1:0] src1_addr;
    logic [reg_addr_len-1:0] src2_addr;
    logic [reg_addr_len-1:0] dest_addr;
    logic                    assign_en;
    logic [rob_tag_len-1:0]  assign_tag;
    logic                    src1_busy;
    logic [rob_tag_len-1:0]  src1_tag;
    logic                    src2_busy;
    logic [rob_tag_len-1:0]  src2_tag;

    modport dispatch (
        output src1_addr, src2_addr, dest_addr, assign_en, assign_tag,
        input  src1_busy, src1_tag, src2_busy, src2_tag
    );

    modport map (
        input  src1_addr, src2_addr, dest_addr, assign_en, assign_tag,
        output src1_busy, src1_tag, src2_busy, src2_tag
    );
endinterface

// allocation and operand reads into the ROB
interface rob_if
    import dispatch_pkg::*;
();
    logic                    alloc;
    logic [reg_addr_len-1:0] alloc_dest;
    logic [xlen-1:0]         alloc_npc;
    logic [rob_tag_len-1:0]  alloc_tag;
    logic                    full;
    logic [rob_tag_len-1:0]  rd_tag1;
    logic [rob_tag_len-1:0]  rd_tag2;
    logic                    rd_done1;
    logic                    rd_done2;
    logic [xlen-1:0]         rd_data1;
    logic [xlen-1:0]         rd_data2;

    modport dispatch (
        output alloc, alloc_dest, alloc_npc, rd_tag1, rd_tag2,
        input  alloc_tag, full, rd_done1, rd_done2, rd_data1, rd_data2
    );

    modport buffer (
        input  alloc, alloc_dest, alloc_npc, rd_tag1, rd_tag2,
        output alloc_tag, full, rd_done1, rd_done2, rd_data1, rd_data2
    );
endinterface

// in-order retirement from the ROB head
interface commit_if
    import dispatch_pkg::*;
();
    logic                    valid;
    logic [rob_tag_len-1:0]  tag;
    logic [reg_addr_len-1:0] dest;
    logic [xlen-1:0]         data;

    modport source (output valid, tag, dest, data);
    modport sink (input valid, tag, dest, data);
endinterface

`default_nettype wire

// File: inst_latch.sv
`timescale 1ns/10ps
`default_nettype none

module inst_latch
    import dispatch_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  fu_t                     in_fu,
    input  logic [3:0]              in_func,
    input  logic [reg_addr_len-1:0] in_dest,
    input  logic [reg_addr_len-1:0] in_src1,
    input  logic [reg_addr_len-1:0] in_src2,
    input  logic [xlen-1:0]         in_imm,
    input  logic                    in_imm_valid,
    input  logic [xlen-1:0]         in_pc,
    input  logic                    in_pc_valid,
    input  logic                    stall,
    output decoded_pack_t           inst
);

    decoded_pack_t in_pack;

    always_comb begin
        in_pack.valid     = in_valid;
        in_pack.fu        = in_fu;
        in_pack.func      = in_func;
        in_pack.dest      = in_dest;
        in_pack.src1      = in_src1;
        in_pack.src2      = in_src2;
        in_pack.imm       = in_imm;
        in_pack.imm_valid = in_imm_valid;
        in_pack.pc        = in_pc;
        in_pack.pc_valid  = in_pc_valid;
    end

    // held while stalled, replaced once the held one fires
    always_ff @(posedge clk) begin
        if (reset) begin
            inst.valid <= 1'b0;
        end else if (!stall) begin
            inst <= in_pack;
        end
    end

endmodule

`default_nettype wire

// File: map_table.sv
`timescale 1ns/10ps
`default_nettype none

module map_table
    import dispatch_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    rename_if.map     ren,
    commit_if.sink    cmt
);

    logic [reg_num-1:0]     busy;
    logic [rob_tag_len-1:0] tags [reg_num];

    // lookups see the table before this cycle's update
    assign ren.src1_busy = busy[ren.src1_addr];
    assign ren.src1_tag  = tags[ren.src1_addr];
    assign ren.src2_busy = busy[ren.src2_addr];
    assign ren.src2_tag  = tags[ren.src2_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
            for (int i = 0; i < reg_num; i++) begin
                tags[i] <= '0;
            end
        end else begin
            // only the newest producer may release the register
            if (cmt.valid && busy[cmt.dest] && tags[cmt.dest] == cmt.tag) begin
                busy[cmt.dest] <= 1'b0;
            end
            // later assignment, so a rename in the same cycle wins
            if (ren.assign_en && ren.dest_addr != '0) begin
                busy[ren.dest_addr] <= 1'b1;
                tags[ren.dest_addr] <= ren.assign_tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer
    import dispatch_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    rob_if.buffer                  rob,
    input  logic                   cdb_valid,
    input  logic [rob_tag_len-1:0] cdb_tag,
    input  logic [xlen-1:0]        cdb_data,
    commit_if.source               cmt,
    output logic [xlen-1:0]        commit_npc
);

    rob_entry_t entries [rob_size];

    logic [rob_tag_len-1:0] head;
    logic [rob_tag_len-1:0] tail;
    logic [rob_tag_len:0]   count;

    assign rob.alloc_tag = tail;
    assign rob.full      = (count == rob_size);

    // operand reads for the dispatcher
    assign rob.rd_done1 = entries[rob.rd_tag1].busy && entries[rob.rd_tag1].done;
    assign rob.rd_data1 = entries[rob.rd_tag1].value;
    assign rob.rd_done2 = entries[rob.rd_tag2].busy && entries[rob.rd_tag2].done;
    assign rob.rd_data2 = entries[rob.rd_tag2].value;

    // head retires as soon as it is done
    assign cmt.valid  = entries[head].busy && entries[head].done;
    assign cmt.tag    = head;
    assign cmt.dest   = entries[head].dest;
    assign cmt.data   = entries[head].value;
    assign commit_npc = entries[head].npc;

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_size; i++) begin
                entries[i].busy <= 1'b0;
                entries[i].done <= 1'b0;
            end
        end else begin
            if (rob.alloc) begin
                entries[tail].busy <= 1'b1;
                entries[tail].done <= 1'b0;
                entries[tail].dest <= rob.alloc_dest;
                entries[tail].npc  <= rob.alloc_npc;
                tail               <= tail + 1'b1;
            end
            // write-back from the CDB
            if (cdb_valid) begin
                entries[cdb_tag].done  <= 1'b1;
                entries[cdb_tag].value <= cdb_data;
            end
            if (cmt.valid) begin
                entries[head].busy <= 1'b0;
                head               <= head + 1'b1;
            end
            case ({rob.alloc, cmt.valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_alloc_when_full: assert property (
        @(posedge clk) disable iff (reset) rob.alloc |-> !rob.full
    );

    // a broadcast must target an allocated entry still waiting for its result
    a_cdb_to_pending: assert property (
        @(posedge clk) disable iff (reset)
        cdb_valid |-> (entries[cdb_tag].busy && !entries[cdb_tag].done)
    );

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file
    import dispatch_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    commit_if.sink                  cmt,
    input  logic [reg_addr_len-1:0] rd_addr1,
    input  logic [reg_addr_len-1:0] rd_addr2,
    output logic [xlen-1:0]         rd_data1,
    output logic [xlen-1:0]         rd_data2
);

    logic [xlen-1:0] regs [reg_num];

    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

    // x0 is never written, so it reads zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_num; i++) begin
                regs[i] <= '0;
            end
        end else if (cmt.valid && cmt.dest != '0) begin
            regs[cmt.dest] <= cmt.data;
        end
    end

endmodule

`default_nettype wire

// File: dispatcher.sv
`timescale 1ns/10ps
`default_nettype none

module dispatcher
    import dispatch_pkg::*;
(
    input  decoded_pack_t           inst,
    input  logic [fu_num-1:0]       rs_full,
    rename_if.dispatch              ren,
    rob_if.dispatch                 rob,
    output logic [reg_addr_len-1:0] reg_rd_addr1,
    output logic [reg_addr_len-1:0] reg_rd_addr2,
    input  logic [xlen-1:0]         reg_rd_data1,
    input  logic [xlen-1:0]         reg_rd_data2,
    output logic                    stall,
    output logic [fu_num-1:0]       rs_load,
    output logic [3:0]              rs_func,
    output logic [rob_tag_len-1:0]  rs_tag_dest,
    output logic [rob_tag_len-1:0]  rs_tag_src1,
    output logic [rob_tag_len-1:0]  rs_tag_src2,
    output logic                    rs_ready_src1,
    output logic                    rs_ready_src2,
    output logic [xlen-1:0]         rs_value_src1,
    output logic [xlen-1:0]         rs_value_src2,
    output logic [xlen-1:0]         rs_imm,
    output logic [xlen-1:0]         rs_pc
);

    typedef struct packed {
        logic                   ready;
        logic [rob_tag_len-1:0] tag;
        logic [xlen-1:0]        value;
    } operand_t;

    logic     fire;
    logic     is_btu;
    operand_t opnd1;
    operand_t opnd2;

    // pc/imm field first, then register file, finished ROB entry and pending tag
    function automatic operand_t pick_operand(
        input logic                    subst,
        input logic [xlen-1:0]         subst_value,
        input logic [reg_addr_len-1:0] addr,
        input logic                    busy,
        input logic [rob_tag_len-1:0]  tag,
        input logic                    done,
        input logic [xlen-1:0]         rob_value,
        input logic [xlen-1:0]         reg_value
    );
        operand_t op;
        if (subst) begin
            op = '{ready: 1'b1, tag: '0, value: subst_value};
        end else if (!busy || addr == '0) begin
            op = '{ready: 1'b1, tag: '0, value: reg_value};
        end else if (done) begin
            op = '{ready: 1'b1, tag: tag, value: rob_value};
        end else begin
            op = '{ready: 1'b0, tag: tag, value: '0};
        end
        return op;
    endfunction

    assign is_btu = (inst.fu == fu_btu);
    assign fire   = inst.valid && !rs_full[inst.fu] && !rob.full;
    assign stall  = inst.valid && !fire;

    always_comb begin
        rs_load = '0;
        if (fire) begin
            rs_load[inst.fu] = 1'b1;
        end
    end

    // rename request
    assign ren.src1_addr  = inst.src1;
    assign ren.src2_addr  = inst.src2;
    assign ren.dest_addr  = inst.dest;
    assign ren.assign_en  = fire;
    assign ren.assign_tag = rob.alloc_tag;

    // ROB allocation and operand reads
    assign rob.alloc      = fire;
    assign rob.alloc_dest = inst.dest;
    assign rob.alloc_npc  = inst.pc + 32'd4;
    assign rob.rd_tag1    = ren.src1_tag;
    assign rob.rd_tag2    = ren.src2_tag;

    assign reg_rd_addr1 = inst.src1;
    assign reg_rd_addr2 = inst.src2;

    assign opnd1 = pick_operand(!is_btu && inst.pc_valid, inst.pc, inst.src1,
                                ren.src1_busy, ren.src1_tag, rob.rd_done1,
                                rob.rd_data1, reg_rd_data1);
    assign opnd2 = pick_operand(!is_btu && inst.imm_valid, inst.imm, inst.src2,
                                ren.src2_busy, ren.src2_tag, rob.rd_done2,
                                rob.rd_data2, reg_rd_data2);

    // RS entry
    assign rs_func       = inst.func;
    assign rs_tag_dest   = rob.alloc_tag;
    assign rs_tag_src1   = opnd1.tag;
    assign rs_tag_src2   = opnd2.tag;
    assign rs_ready_src1 = opnd1.ready;
    assign rs_ready_src2 = opnd2.ready;
    assign rs_value_src1 = opnd1.value;
    assign rs_value_src2 = opnd2.value;
    // branch unit needs its own pc and offset
    assign rs_imm        = is_btu ? inst.imm : '0;
    assign rs_pc         = is_btu ? inst.pc : '0;

endmodule

`default_nettype wire

// File: dispatch_top.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch_top
    import dispatch_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  fu_t                     in_fu,
    input  logic [3:0]              in_func,
    input  logic [reg_addr_len-1:0] in_dest,
    input  logic [reg_addr_len-1:0] in_src1,
    input  logic [reg_addr_len-1:0] in_src2,
    input  logic [xlen-1:0]         in_imm,
    input  logic                    in_imm_valid,
    input  logic [xlen-1:0]         in_pc,
    input  logic                    in_pc_valid,
    output logic                    stall,
    input  logic                    cdb_valid,
    input  logic [rob_tag_len-1:0]  cdb_tag,
    input  logic [xlen-1:0]         cdb_data,
    input  logic [fu_num-1:0]       rs_full,
    output logic [fu_num-1:0]       rs_load,
    output logic [3:0]              rs_func,
    output logic [rob_tag_len-1:0]  rs_tag_dest,
    output logic [rob_tag_len-1:0]  rs_tag_src1,
    output logic [rob_tag_len-1:0]  rs_tag_src2,
    output logic                    rs_ready_src1,
    output logic                    rs_ready_src2,
    output logic [xlen-1:0]         rs_value_src1,
    output logic [xlen-1:0]         rs_value_src2,
    output logic [xlen-1:0]         rs_imm,
    output logic [xlen-1:0]         rs_pc,
    output logic                    commit_valid,
    output logic [reg_addr_len-1:0] commit_dest,
    output logic [xlen-1:0]         commit_data,
    output logic [xlen-1:0]         commit_npc
);

    decoded_pack_t           inst;
    logic [reg_addr_len-1:0] reg_rd_addr1;
    logic [reg_addr_len-1:0] reg_rd_addr2;
    logic [xlen-1:0]         reg_rd_data1;
    logic [xlen-1:0]         reg_rd_data2;

    rename_if ren_bus ();
    rob_if    rob_bus ();
    commit_if cmt_bus ();

    assign commit_valid = cmt_bus.valid;
    assign commit_dest  = cmt_bus.dest;
    assign commit_data  = cmt_bus.data;

    inst_latch u_latch (
        .clk, .reset, .in_valid, .in_fu, .in_func, .in_dest, .in_src1, .in_src2,
        .in_imm, .in_imm_valid, .in_pc, .in_pc_valid, .stall, .inst
    );

    map_table u_map (.clk, .reset, .ren(ren_bus), .cmt(cmt_bus));

    reorder_buffer u_rob (
        .clk, .reset, .rob(rob_bus), .cdb_valid, .cdb_tag, .cdb_data,
        .cmt(cmt_bus), .commit_npc
    );

    reg_file u_regs (
        .clk, .reset, .cmt(cmt_bus), .rd_addr1(reg_rd_addr1), .rd_addr2(reg_rd_addr2),
        .rd_data1(reg_rd_data1), .rd_data2(reg_rd_data2)
    );

    dispatcher u_disp (
        .inst, .rs_full, .ren(ren_bus), .rob(rob_bus),
        .reg_rd_addr1, .reg_rd_addr2, .reg_rd_data1, .reg_rd_data2,
        .stall, .rs_load, .rs_func, .rs_tag_dest, .rs_tag_src1, .rs_tag_src2,
        .rs_ready_src1, .rs_ready_src2, .rs_value_src1, .rs_value_src2, .rs_imm, .rs_pc
    );

endmodule

`default_nettype wire

// File: tb_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dispatch
    import dispatch_pkg::*;
();

    // one row of stimulus per clock cycle
    typedef struct packed {
        logic                    valid;
        fu_t                     fu;
        logic [3:0]              func;
        logic [reg_addr_len-1:0] dest;
        logic [reg_addr_len-1:0] src1;
        logic [reg_addr_len-1:0] src2;
        logic [xlen-1:0]         imm;
        logic                    imm_valid;
        logic [xlen-1:0]         pc;
        logic                    pc_valid;
        logic [fu_num-1:0]       full;
        logic                    cdb_valid;
        logic [rob_tag_len-1:0]  cdb_tag;
        logic [xlen-1:0]         cdb_data;
        logic                    cdb_rand;
    } row_t;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    in_valid;
    fu_t                     in_fu;
    logic [3:0]              in_func;
    logic [reg_addr_len-1:0] in_dest;
    logic [reg_addr_len-1:0] in_src1;
    logic [reg_addr_len-1:0] in_src2;
    logic [xlen-1:0]         in_imm;
    logic                    in_imm_valid;
    logic [xlen-1:0]         in_pc;
    logic                    in_pc_valid;
    logic                    stall;
    logic                    cdb_valid;
    logic [rob_tag_len-1:0]  cdb_tag;
    logic [xlen-1:0]         cdb_data;
    logic [fu_num-1:0]       rs_full;
    logic [fu_num-1:0]       rs_load;
    logic [3:0]              rs_func;
    logic [rob_tag_len-1:0]  rs_tag_dest;
    logic [rob_tag_len-1:0]  rs_tag_src1;
    logic [rob_tag_len-1:0]  rs_tag_src2;
    logic                    rs_ready_src1;
    logic                    rs_ready_src2;
    logic [xlen-1:0]         rs_value_src1;
    logic [xlen-1:0]         rs_value_src2;
    logic [xlen-1:0]         rs_imm;
    logic [xlen-1:0]         rs_pc;
    logic                    commit_valid;
    logic [reg_addr_len-1:0] commit_dest;
    logic [xlen-1:0]         commit_data;
    logic [xlen-1:0]         commit_npc;

    // reference model state
    logic                    map_busy [reg_num];
    logic [rob_tag_len-1:0]  map_tag  [reg_num];
    logic [xlen-1:0]         regs_m   [reg_num];
    logic                    ent_busy [rob_size];
    logic                    ent_done [rob_size];
    logic [reg_addr_len-1:0] ent_dest [rob_size];
    logic [xlen-1:0]         ent_npc  [rob_size];
    logic [xlen-1:0]         ent_val  [rob_size];
    logic [rob_tag_len-1:0]  head;
    logic [rob_tag_len-1:0]  tail;
    int                      count;
    row_t                    lat;
    row_t                    cur;
    logic                    held;
    integer                  seed;
    row_t                    rows [$];

    dispatch_top UUT (.*);

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [xlen-1:0] actual,
                               input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED time %0t: %s got %0h expected %0h",
                     $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopping on the first mismatch");
        end
    endtask

    task automatic add_row(input logic v, input fu_t fu, input logic [3:0] func,
                           input logic [reg_addr_len-1:0] dest, src1, src2,
                           input logic [xlen-1:0] imm, input logic iv,
                           input logic [xlen-1:0] pc, input logic pv,
                           input logic [fu_num-1:0] full, input logic cv,
                           input logic [rob_tag_len-1:0] ct, input logic [xlen-1:0] cd,
                           input logic rnd);
        row_t r;
        r = '{v, fu, func, dest, src1, src2, imm, iv, pc, pv, full, cv, ct, cd, rnd};
        rows.push_back(r);
    endtask

    task automatic add_wait(input int n, input logic [fu_num-1:0] full);
        repeat (n) add_row(0, fu_alu, 0, 0, 0, 0, 0, 0, 0, 0, full, 0, 0, 0, 0);
    endtask

    task automatic add_cdb(input logic [rob_tag_len-1:0] tag, input logic [xlen-1:0] data,
                           input logic rnd);
        add_row(0, fu_alu, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, tag, data, rnd);
    endtask

    task automatic apply_inputs(input row_t r);
        in_valid     = r.valid;
        in_fu        = r.fu;
        in_func      = r.func;
        in_dest      = r.dest;
        in_src1      = r.src1;
        in_src2      = r.src2;
        in_imm       = r.imm;
        in_imm_valid = r.imm_valid;
        in_pc        = r.pc;
        in_pc_valid  = r.pc_valid;
    endtask

    // expected operand as the model sees it
    task automatic predict_operand(input logic subst, input logic [xlen-1:0] subst_val,
                                   input logic [reg_addr_len-1:0] addr,
                                   output logic ready, output logic [rob_tag_len-1:0] tag,
                                   output logic [xlen-1:0] value, output logic care);
        ready = 1'b1;
        tag   = '0;
        care  = 1'b1;
        value = '0;
        if (subst) begin
            value = subst_val;
        end else if (addr == 0 || !map_busy[addr]) begin
            value = regs_m[addr];
            care  = 1'b0;
        end else if (ent_done[map_tag[addr]]) begin
            value = ent_val[map_tag[addr]];
            care  = 1'b0;
        end else begin
            ready = 1'b0;
            tag   = map_tag[addr];
        end
    endtask

    task automatic step(input row_t r);
        logic                    fire;
        logic                    exp_stall;
        logic [fu_num-1:0]       exp_load;
        logic                    exp_commit;
        logic                    btu;
        logic                    rdy1;
        logic                    rdy2;
        logic                    care1;
        logic                    care2;
        logic [rob_tag_len-1:0]  tag1;
        logic [rob_tag_len-1:0]  tag2;
        logic [xlen-1:0]         val1;
        logic [xlen-1:0]         val2;
        logic [reg_addr_len-1:0] cdest;
        @(posedge clk);
        #1;
        if (held && r.valid) begin
            $display("Simulation failed");
            $fatal(1, "a table row offers a new instruction while the input is held");
        end
        // upstream keeps its instruction while stalled
        if (!held) begin
            cur = r;
        end
        apply_inputs(cur);
        rs_full   = r.full;
        cdb_valid = r.cdb_valid;
        cdb_tag   = r.cdb_tag;
        cdb_data  = r.cdb_rand ? $random(seed) : r.cdb_data;
        @(negedge clk);
        btu        = (lat.fu == fu_btu);
        fire       = lat.valid && !r.full[lat.fu] && count < rob_size;
        exp_stall  = lat.valid && !fire;
        exp_load   = fire ? (4'b0001 << lat.fu) : 4'b0000;
        exp_commit = ent_busy[head] && ent_done[head];
        predict_operand(!btu && lat.pc_valid, lat.pc, lat.src1, rdy1, tag1, val1, care1);
        predict_operand(!btu && lat.imm_valid, lat.imm, lat.src2, rdy2, tag2, val2, care2);
        check_value("stall", 32'(stall), 32'(exp_stall));
        check_value("rs_load", 32'(rs_load), 32'(exp_load));
        check_value("commit_valid", 32'(commit_valid), 32'(exp_commit));
        if (fire) begin
            check_value("rs_func", 32'(rs_func), 32'(lat.func));
            check_value("rs_tag_dest", 32'(rs_tag_dest), 32'(tail));
            check_value("rs_ready_src1", 32'(rs_ready_src1), 32'(rdy1));
            check_value("rs_ready_src2", 32'(rs_ready_src2), 32'(rdy2));
            check_value("rs_value_src1", rs_value_src1, val1);
            check_value("rs_value_src2", rs_value_src2, val2);
            if (care1) begin
                check_value("rs_tag_src1", 32'(rs_tag_src1), 32'(tag1));
            end
            if (care2) begin
                check_value("rs_tag_src2", 32'(rs_tag_src2), 32'(tag2));
            end
            check_value("rs_imm", rs_imm, btu ? lat.imm : 32'd0);
            check_value("rs_pc", rs_pc, btu ? lat.pc : 32'd0);
        end
        if (exp_commit) begin
            check_value("commit_dest", 32'(commit_dest), 32'(ent_dest[head]));
            check_value("commit_data", commit_data, ent_val[head]);
            check_value("commit_npc", commit_npc, ent_npc[head]);
        end
        // commit goes before rename when the model advances
        if (exp_commit) begin
            cdest = ent_dest[head];
            if (cdest != 0) begin
                regs_m[cdest] = ent_val[head];
            end
            if (map_busy[cdest] && map_tag[cdest] == head) begin
                map_busy[cdest] = 1'b0;
            end
            ent_busy[head] = 1'b0;
            head           = head + 3'd1;
            count          = count - 1;
        end
        if (cdb_valid) begin
            ent_done[cdb_tag] = 1'b1;
            ent_val[cdb_tag]  = cdb_data;
        end
        if (fire) begin
            ent_busy[tail] = 1'b1;
            ent_done[tail] = 1'b0;
            ent_dest[tail] = lat.dest;
            ent_npc[tail]  = lat.pc + 32'd4;
            if (lat.dest != 0) begin
                map_busy[lat.dest] = 1'b1;
                map_tag[lat.dest]  = tail;
            end
            tail  = tail + 3'd1;
            count = count + 1;
        end
        if (!exp_stall) begin
            lat = cur;
        end
        held = exp_stall;
    endtask

    initial begin
        row_t idle;
        int   waited;
        idle  = '0;
        seed  = 67;
        held  = 1'b0;
        cur   = '0;
        lat   = '0;
        head  = '0;
        tail  = '0;
        count = 0;
        for (int i = 0; i < reg_num; i++) begin
            map_busy[i] = 1'b0;
            map_tag[i]  = '0;
            regs_m[i]   = '0;
        end
        for (int i = 0; i < rob_size; i++) begin
            ent_busy[i] = 1'b0;
            ent_done[i] = 1'b0;
        end
        reset     = 1'b1;
        rs_full   = '0;
        cdb_valid = 1'b0;
        cdb_tag   = '0;
        cdb_data  = '0;
        apply_inputs(idle);

        // valid fu func dest src1 src2 imm imm_v pc pc_v rs_full cdb_v cdb_tag cdb_data rand
        add_wait(1, 0);
        add_row(1, fu_alu,  1, 3, 1, 2, 0,    0, 'h100, 0, 0, 0, 0, 0,      0);
        add_row(1, fu_mult, 2, 4, 3, 0, 0,    0, 'h104, 0, 0, 0, 0, 0,      0);
        add_row(1, fu_btu,  3, 0, 4, 3, 'h40, 1, 'h200, 1, 0, 0, 0, 0,      0);
        add_row(1, fu_lsu,  4, 5, 6, 7, 'h10, 1, 'h300, 1, 0, 1, 1, 'h1111, 0);
        add_row(1, fu_alu,  5, 6, 4, 5, 0,    0, 'h304, 0, 0, 0, 0, 0,      0);
        add_row(1, fu_mult, 6, 4, 3, 6, 0,    0, 'h308, 0, 0, 0, 0, 0,      0);
        // results arrive out of order and x4 keeps its newer mapping
        add_cdb(3, 0, 1);
        add_cdb(0, 'ha0a0, 0);
        add_cdb(2, 'h2222, 0);
        add_row(1, fu_alu,  7, 8, 3, 4, 0,    0, 'h30c, 0, 0, 0, 0, 0,      0);
        add_wait(1, 0);
        add_row(1, fu_lsu,  8, 9, 5, 4, 0,    0, 'h310, 0, 0, 0, 0, 0,      0);
        add_row(1, fu_alu,  9, 10, 8, 9, 0,   0, 'h314, 0, 0, 0, 0, 0,      0);
        // alu station full for two cycles
        add_wait(2, 4'b0001);
        add_wait(1, 0);
        for (int t = 4; t < 9; t++) begin
            add_cdb(3'(t), 0, 1);
        end
        add_wait(1, 0);
        // nine dispatches into an empty ROB where the last one stalls
        for (int i = 0; i < 9; i++) begin
            add_row(1, fu_t'(i[1:0]), 4'(i), 5'(11 + i), 3, 5, 0, 0,
                    32'('h600 + 4 * i), 0, 0, 0, 0, 0, 0);
        end
        add_wait(2, 0);
        add_cdb(1, 0, 1);
        add_wait(2, 0);
        for (int t = 2; t < 10; t++) begin
            add_cdb(3'(t), 0, 1);
        end

        // outputs stay low during and right after reset
        @(posedge clk);
        #1;
        check_value("stall", 32'(stall), 32'd0);
        check_value("rs_load", 32'(rs_load), 32'd0);
        check_value("commit_valid", 32'(commit_valid), 32'd0);
        @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("stall", 32'(stall), 32'd0);
        check_value("rs_load", 32'(rs_load), 32'd0);
        check_value("commit_valid", 32'(commit_valid), 32'd0);

        foreach (rows[k]) begin
            step(rows[k]);
        end

        // let the remaining entries retire
        waited = 0;
        while (count != 0) begin
            if (waited == 20) begin
                $display("Simulation failed");
                $fatal(1, "ROB still holds %0d entries after %0d idle cycles", count, waited);
            end
            step(idle);
            waited++;
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
dispatch_pkg.sv
dispatch_ifs.sv
inst_latch.sv
map_table.sv
reorder_buffer.sv
reg_file.sv
dispatcher.sv
dispatch_top.sv
tb_dispatch.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
# a failing run ends in $fatal, which gives a non-zero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_dispatch \
    -f compile.f \
    -o tb_dispatch

./obj_dir/tb_dispatch
